// File: hw/addr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module addr_unit #(
	parameter int ADDR_W = 13
) (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::addr_cmd_e cmd,
	input  cpu_pkg::data_t     dbus_in,
	output logic [ADDR_W-1:0]  adr
);

	logic [ADDR_W-1:0] pc;
	logic [4:0]        hi;       // Upper address bits from the first byte
	logic [12:0]       abs_addr;
	logic [ADDR_W-1:0] disp;

	assign abs_addr = {hi, dbus_in};

	// 7-bit two's complement displacement, indirect bit ignored
	assign disp = {{(ADDR_W-7){dbus_in[6]}}, dbus_in[6:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			pc  <= '0;
			adr <= '0;
		end else begin
			case (cmd)
				cpu_pkg::ac_fetch: begin
					adr <= pc;
					pc  <= pc + 1'b1;
				end
				cpu_pkg::ac_abs_hi: begin
					adr <= pc; // Second address byte follows
					pc  <= pc + 1'b1;
				end
				cpu_pkg::ac_abs_lo: begin
					adr <= ADDR_W'(abs_addr);
				end
				cpu_pkg::ac_rel_branch: begin
					pc <= pc + disp;
				end
				cpu_pkg::ac_abs_branch: begin
					pc <= ADDR_W'(abs_addr);
				end
				cpu_pkg::ac_skip: begin
					pc <= pc + 2'd2; // Over both address bytes
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (cmd == cpu_pkg::ac_abs_hi) begin
			hi <= dbus_in[4:0]; // Index and indirect bits dropped
		end
	end

	a_abs_lo_order: assert property (@(posedge clk) disable iff (reset)
		cmd == cpu_pkg::ac_abs_lo |-> $past(cmd) == cpu_pkg::ac_abs_hi);

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_e  op,
	input  cpu_pkg::data_t    a,
	input  cpu_pkg::data_t    b,
	input  cpu_pkg::psl_t     psl,
	output cpu_pkg::alu_res_t res
);

	function automatic cpu_pkg::cc_e cc_of(input cpu_pkg::data_t v);
		if (v[7]) begin
			return cpu_pkg::cc_neg;
		end else if (v == '0) begin
			return cpu_pkg::cc_zero;
		end
		return cpu_pkg::cc_pos;
	endfunction

	cpu_pkg::data_t result;
	logic           add_cin;
	logic           sub_cin;
	logic           a_gt;
	logic           a_lt;

	assign add_cin = psl.wc & psl.c;
	assign sub_cin = psl.wc ? psl.c : 1'b1; // Borrow chain only with wc

	// Logical compare when com is set, arithmetic otherwise
	assign a_gt = psl.com ? (a > b) : ($signed(a) > $signed(b));
	assign a_lt = psl.com ? (a < b) : ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			cpu_pkg::alu_eor: result = a ^ b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_ior: result = a | b;
			cpu_pkg::alu_add: result = a + b + add_cin;
			cpu_pkg::alu_sub: result = a + ~b + sub_cin;
			cpu_pkg::alu_com: result = a; // Only the CC matters
			default:          result = b;
		endcase
	end

	always_comb begin
		res.value = result;
		if (op == cpu_pkg::alu_com) begin
			if (a_gt) begin
				res.cc = cpu_pkg::cc_pos;
			end else if (a_lt) begin
				res.cc = cpu_pkg::cc_neg;
			end else begin
				res.cc = cpu_pkg::cc_zero;
			end
		end else begin
			res.cc = cc_of(result);
		end
		res.c   = result < a;
		res.ovf = (a[7] == b[7]) && (result[7] != a[7]);
		res.idc = result[4];
	end

endmodule

`default_nettype wire

// File: hw/as2650_core.sv
`timescale 1ns/1ns
`default_nettype none

module as2650_core #(
	parameter int ADDR_W = 13
) (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::data_t    dbus_in,
	output cpu_pkg::data_t    dbus_out,
	output logic [ADDR_W-1:0] adr,
	output logic              opreq,
	output logic              rw,
	output logic              wrp,
	input  logic              sense,
	output logic              flag
);

	cpu_pkg::addr_cmd_e   addr_cmd;
	cpu_pkg::reg_sel_t    rd_sel;
	cpu_pkg::data_t       rd_data, r0_data;
	cpu_pkg::reg_wr_t     reg_wr;
	cpu_pkg::status_cmd_t status_cmd;
	cpu_pkg::alu_op_e     alu_op;
	cpu_pkg::data_t       alu_a, alu_b;
	cpu_pkg::alu_res_t    alu_res;
	cpu_pkg::psl_t        psl;
	cpu_pkg::data_t       psu;

	cpu_sequencer cpu_sequencer_inst (.clk, .reset, .dbus_in, .rd_data, .r0_data,
		.alu_res, .psl, .psu, .addr_cmd, .rd_sel, .reg_wr, .status_cmd, .alu_op,
		.alu_a, .alu_b, .opreq, .rw, .wrp, .dbus_out);

	addr_unit #(.ADDR_W(ADDR_W)) addr_unit_inst (.clk, .reset, .cmd(addr_cmd),
		.dbus_in, .adr);

	reg_file reg_file_inst (.clk, .reset, .rs(psl.rs), .rd_sel, .rd_data, .r0_data,
		.wr(reg_wr));

	alu alu_inst (.op(alu_op), .a(alu_a), .b(alu_b), .psl, .res(alu_res));

	status_regs status_regs_inst (.clk, .reset, .sense, .cmd(status_cmd), .alu_res,
		.psu, .psl, .flag);

endmodule

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int DATA_W = 8;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [1:0] reg_sel_t; // 0 is r0

	// Values follow opcode bits 7:5, code 6 is the store group
	typedef enum logic [2:0] {
		alu_load = 3'd0,
		alu_eor  = 3'd1,
		alu_and  = 3'd2,
		alu_ior  = 3'd3,
		alu_add  = 3'd4,
		alu_sub  = 3'd5,
		alu_com  = 3'd7
	} alu_op_e;

	typedef enum logic [1:0] {
		cc_zero = 2'd0,
		cc_pos  = 2'd1,
		cc_neg  = 2'd2
	} cc_e;

	typedef struct packed {
		cc_e  cc;  // Bits 7:6
		logic idc;
		logic rs;  // Register bank select
		logic wc;  // With carry
		logic ovf;
		logic com; // Logical compare
		logic c;
	} psl_t;

	typedef struct packed {
		data_t value;
		cc_e   cc;
		logic  c;
		logic  ovf;
		logic  idc;
	} alu_res_t;

	typedef struct packed {
		logic     en;
		reg_sel_t sel;
		data_t    data;
	} reg_wr_t;

	typedef struct packed {
		logic  cc_en;
		cc_e   cc;
		logic  arith_en; // Take c, ovf and idc from the ALU
		logic  load_psu;
		logic  load_psl;
		data_t data;
	} status_cmd_t;

	typedef enum logic [2:0] {
		ac_hold,
		ac_fetch,      // adr from pc, pc advances
		ac_abs_hi,
		ac_abs_lo,
		ac_rel_branch,
		ac_abs_branch,
		ac_skip        // Untaken absolute branch
	} addr_cmd_e;

	typedef enum logic [3:0] {
		st_fetch,
		st_latch,
		st_exec,
		st_operand,
		st_alu,
		st_abs_hi,
		st_abs_lo,
		st_br_hi,
		st_store,
		st_store_end,
		st_halted
	} seq_state_e;

	localparam data_t OP_HALT = 8'h40;
	localparam data_t OP_NOP  = 8'hC0;
	localparam data_t OP_SPSU = 8'h12;
	localparam data_t OP_SPSL = 8'h13;
	localparam data_t OP_LPSU = 8'h92;
	localparam data_t OP_LPSL = 8'h93;

endpackage

`default_nettype wire

// File: hw/cpu_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  cpu_pkg::data_t       dbus_in,
	input  cpu_pkg::data_t       rd_data,
	input  cpu_pkg::data_t       r0_data,
	input  cpu_pkg::alu_res_t    alu_res,
	input  cpu_pkg::psl_t        psl,
	input  cpu_pkg::data_t       psu,
	output cpu_pkg::addr_cmd_e   addr_cmd,
	output cpu_pkg::reg_sel_t    rd_sel,
	output cpu_pkg::reg_wr_t     reg_wr,
	output cpu_pkg::status_cmd_t status_cmd,
	output cpu_pkg::alu_op_e     alu_op,
	output cpu_pkg::data_t       alu_a,
	output cpu_pkg::data_t       alu_b,
	output logic                 opreq,
	output logic                 rw,
	output logic                 wrp,
	output cpu_pkg::data_t       dbus_out
);

	cpu_pkg::data_t      ir;
	cpu_pkg::data_t      hold;  // Immediate or memory operand
	cpu_pkg::seq_state_e state;

	logic [2:0]        op3;
	logic [1:0]        mode;  // 0 zero, 1 immediate, 3 absolute
	cpu_pkg::reg_sel_t rsel;
	logic              is_halt, grp_alu, is_store, is_arith, is_com;
	logic              do_zero, do_imm, do_abs;
	logic              is_bctr, is_bcfr, is_branch, br_abs, br_taken;
	logic              is_spsu, is_spsl, is_lpsu, is_lpsl;
	logic              commit;

	assign op3  = ir[7:5];
	assign mode = ir[3:2];
	assign rsel = ir[1:0];

	assign is_halt  = ir == cpu_pkg::OP_HALT;
	assign grp_alu  = !ir[4] && !is_halt && ir != cpu_pkg::OP_NOP;
	assign is_store = op3 == 3'd6;
	assign is_arith = op3 == 3'd4 || op3 == 3'd5;
	assign is_com   = op3 == 3'd7;
	assign do_zero  = grp_alu && mode == 2'd0;
	assign do_imm   = grp_alu && mode == 2'd1 && !is_store; // No immediate store
	assign do_abs   = grp_alu && mode == 2'd3;

	assign is_bctr   = ir[7:3] == 5'b00011;
	assign is_bcfr   = ir[7:3] == 5'b10011 && rsel != 2'd3;
	assign is_branch = is_bctr || is_bcfr;
	assign br_abs    = ir[2];
	assign br_taken  = is_bctr ? (rsel == 2'd3 || rsel == psl.cc) : (rsel != psl.cc);

	assign is_spsu = ir == cpu_pkg::OP_SPSU;
	assign is_spsl = ir == cpu_pkg::OP_SPSL;
	assign is_lpsu = ir == cpu_pkg::OP_LPSU;
	assign is_lpsl = ir == cpu_pkg::OP_LPSL;

	// Stores move data through the ALU as a plain load
	assign alu_op = is_store ? cpu_pkg::alu_load : cpu_pkg::alu_op_e'(op3);
	assign rd_sel = rsel;
	assign alu_a  = (mode == 2'd0) ? r0_data : rd_data;

	always_comb begin
		if (is_spsu) begin
			alu_b = psu;
		end else if (is_spsl) begin
			alu_b = psl;
		end else if (mode == 2'd0) begin
			alu_b = is_store ? r0_data : rd_data; // strz copies r0 out
		end else begin
			alu_b = hold;
		end
	end

	assign commit = (state == cpu_pkg::st_exec && do_zero) || state == cpu_pkg::st_alu;

	always_comb begin
		addr_cmd        = cpu_pkg::ac_hold;
		reg_wr          = '0;
		reg_wr.data     = alu_res.value;
		status_cmd      = '0;
		status_cmd.cc   = alu_res.cc;
		status_cmd.data = r0_data;
		if (commit) begin
			status_cmd.cc_en    = 1'b1;
			status_cmd.arith_en = is_arith;
			reg_wr.en           = !is_com;
			reg_wr.sel          = (mode == 2'd0 && !is_store) ? 2'd0 : rsel;
		end
		case (state)
			cpu_pkg::st_fetch: addr_cmd = cpu_pkg::ac_fetch;
			cpu_pkg::st_exec: begin
				if (do_imm || do_abs) begin
					addr_cmd = cpu_pkg::ac_fetch;
				end else if (is_branch) begin
					addr_cmd = (!br_taken && br_abs) ? cpu_pkg::ac_skip : cpu_pkg::ac_fetch;
				end else if (is_spsu || is_spsl) begin
					reg_wr.en          = 1'b1;
					status_cmd.cc_en   = 1'b1;
				end else begin
					status_cmd.load_psu = is_lpsu;
					status_cmd.load_psl = is_lpsl;
				end
			end
			cpu_pkg::st_abs_hi: addr_cmd = cpu_pkg::ac_abs_hi;
			cpu_pkg::st_abs_lo: begin
				addr_cmd = is_branch ? cpu_pkg::ac_abs_branch : cpu_pkg::ac_abs_lo;
			end
			cpu_pkg::st_br_hi: addr_cmd = br_abs ? cpu_pkg::ac_abs_hi : cpu_pkg::ac_rel_branch;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpu_pkg::st_fetch;
			ir    <= '0;
			opreq <= 1'b0;
			rw    <= 1'b0;
			wrp   <= 1'b0;
		end else begin
			case (state)
				cpu_pkg::st_fetch: begin
					opreq <= 1'b1;
					rw    <= 1'b0;
					state <= cpu_pkg::st_latch;
				end
				cpu_pkg::st_latch: begin
					ir    <= dbus_in;
					opreq <= 1'b0;
					state <= cpu_pkg::st_exec;
				end
				cpu_pkg::st_exec: begin
					if (is_halt) begin
						state <= cpu_pkg::st_halted;
					end else if (do_imm || do_abs) begin
						opreq <= 1'b1;
						state <= do_imm ? cpu_pkg::st_operand : cpu_pkg::st_abs_hi;
					end else if (is_branch && br_taken) begin
						opreq <= 1'b1;
						state <= cpu_pkg::st_br_hi;
					end else begin
						state <= cpu_pkg::st_fetch; // Also every dropped opcode
					end
				end
				cpu_pkg::st_operand: begin
					hold  <= dbus_in;
					opreq <= 1'b0;
					state <= cpu_pkg::st_alu;
				end
				cpu_pkg::st_abs_hi: state <= cpu_pkg::st_abs_lo;
				cpu_pkg::st_abs_lo: begin
					if (is_branch) begin
						opreq <= 1'b0;
						state <= cpu_pkg::st_fetch;
					end else if (is_store) begin
						rw       <= 1'b1;
						dbus_out <= rd_data;
						state    <= cpu_pkg::st_store;
					end else begin
						state <= cpu_pkg::st_operand;
					end
				end
				cpu_pkg::st_br_hi: begin
					if (br_abs) begin
						state <= cpu_pkg::st_abs_lo;
					end else begin
						opreq <= 1'b0;
						state <= cpu_pkg::st_fetch;
					end
				end
				cpu_pkg::st_store: begin
					wrp   <= 1'b1; // Address and data already stable
					state <= cpu_pkg::st_store_end;
				end
				cpu_pkg::st_store_end: begin
					wrp   <= 1'b0;
					rw    <= 1'b0;
					opreq <= 1'b0;
					state <= cpu_pkg::st_fetch;
				end
				cpu_pkg::st_halted: ; // Only reset leaves
				default: state <= cpu_pkg::st_fetch;
			endcase
		end
	end

	a_wrp_pulse: assert property (@(posedge clk) disable iff (reset)
		wrp |-> rw && opreq ##1 !wrp);

	a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
		state == cpu_pkg::st_halted |=> state == cpu_pkg::st_halted && !opreq);

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic              clk,
	input  logic              reset,
	input  logic              rs,
	input  cpu_pkg::reg_sel_t rd_sel,
	output cpu_pkg::data_t    rd_data,
	output cpu_pkg::data_t    r0_data,
	input  cpu_pkg::reg_wr_t  wr
);

	cpu_pkg::data_t r0;
	cpu_pkg::data_t bank [2][1:3]; // r1..r3 in each bank

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
			for (int b = 0; b < 2; b++) begin
				for (int r = 1; r <= 3; r++) begin
					bank[b][r] <= '0;
				end
			end
		end else if (wr.en) begin
			if (wr.sel == 2'd0) begin
				r0 <= wr.data; // r0 is shared by both banks
			end else begin
				bank[rs][wr.sel] <= wr.data;
			end
		end
	end

	always_comb begin
		if (rd_sel == 2'd0) begin
			rd_data = r0;
		end else begin
			rd_data = bank[rs][rd_sel];
		end
	end

	assign r0_data = r0;

endmodule

`default_nettype wire

// File: hw/status_regs.sv
`timescale 1ns/1ns
`default_nettype none

module status_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 sense,
	input  cpu_pkg::status_cmd_t cmd,
	input  cpu_pkg::alu_res_t    alu_res,
	output cpu_pkg::data_t       psu,
	output cpu_pkg::psl_t        psl,
	output logic                 flag
);

	always_ff @(posedge clk) begin
		if (reset) begin
			psu[6:0] <= '0;
		end else if (cmd.load_psu) begin
			psu[6:0] <= cmd.data[6:0];
		end
	end

	// Sense is a live input, so bit 7 follows it every cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			psu[7] <= 1'b0;
		end else begin
			psu[7] <= sense;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			psl <= '0;
		end else if (cmd.load_psl) begin
			psl <= cpu_pkg::psl_t'(cmd.data); // lpsl takes r0 whole
		end else begin
			if (cmd.cc_en) begin
				psl.cc <= cmd.cc;
			end
			if (cmd.arith_en) begin // add and sub only
				psl.c   <= alu_res.c;
				psl.ovf <= alu_res.ovf;
				psl.idc <= alu_res.idc;
			end
		end
	end

	assign flag = psu[6];

endmodule

`default_nettype wire

// File: sim/ref_model.svh
cpu_pkg::data_t    m_mem [0:8191];
cpu_pkg::data_t    m_r0;
cpu_pkg::data_t    m_bank [2][1:3];
cpu_pkg::data_t    m_psl; // cc 7:6, idc, rs, wc, ovf, com, c
cpu_pkg::data_t    m_psu;
logic              m_sense;
logic [ADDR_W-1:0] exp_rd_addr [$];
logic              exp_rd_flag [$];
logic [ADDR_W-1:0] exp_wr_addr [$];
cpu_pkg::data_t    exp_wr_data [$];

function automatic cpu_pkg::data_t get_reg(input logic [1:0] r);
	if (r == 2'd0) begin
		return m_r0;
	end
	return m_bank[m_psl[4]][r];
endfunction

function automatic void put_reg(input logic [1:0] r, input cpu_pkg::data_t v);
	if (r == 2'd0) begin
		m_r0 = v;
	end else begin
		m_bank[m_psl[4]][r] = v;
	end
endfunction

function automatic logic [1:0] cc_from(input cpu_pkg::data_t v);
	if (v[7]) begin
		return 2'd2;
	end else if (v == 8'h00) begin
		return 2'd0;
	end
	return 2'd1;
endfunction

// Every bus read, with the flag level seen while it happens
function automatic cpu_pkg::data_t read_bus(input logic [ADDR_W-1:0] a);
	exp_rd_addr.push_back(a);
	exp_rd_flag.push_back(m_psu[6]);
	if (sense_mark[a]) begin
		m_sense = sense_val[a];
	end
	return m_mem[a];
endfunction

function automatic void exec_alu(input logic [2:0] op3, input logic [1:0] r,
		input cpu_pkg::data_t b);
	cpu_pkg::data_t a;
	cpu_pkg::data_t res;
	logic           gt;
	logic           lt;
	a = get_reg(r);
	case (op3)
		3'd0: res = b;
		3'd1: res = a ^ b;
		3'd2: res = a & b;
		3'd3: res = a | b;
		3'd4: res = a + b + (m_psl[3] & m_psl[0]);
		3'd5: res = a + ~b + (m_psl[3] ? m_psl[0] : 1'b1);
		default: res = a;
	endcase
	if (op3 == 3'd7) begin
		gt = m_psl[1] ? (a > b) : ($signed(a) > $signed(b));
		lt = m_psl[1] ? (a < b) : ($signed(a) < $signed(b));
		m_psl[7:6] = gt ? 2'd1 : (lt ? 2'd2 : 2'd0);
		return; // Compare keeps the register
	end
	if (op3 == 3'd4 || op3 == 3'd5) begin
		m_psl[0] = res < a;
		m_psl[2] = (a[7] == b[7]) && (res[7] != a[7]);
		m_psl[5] = res[4];
	end
	m_psl[7:6] = cc_from(res);
	put_reg(r, res);
endfunction

task automatic run_model();
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] ea;
	cpu_pkg::data_t    op;
	cpu_pkg::data_t    b1;
	cpu_pkg::data_t    b2;
	logic [1:0]        r;
	logic              taken;
	logic              running;
	for (int i = 0; i < 8192; i++) begin
		m_mem[i] = mem[i];
	end
	m_r0 = '0;
	m_bank = '{default: '0};
	m_psl = '0;
	m_psu = '0;
	m_sense = 1'b0;
	pc = '0;
	running = 1'b1;
	while (running) begin
		op = read_bus(pc);
		pc++;
		r = op[1:0];
		if (op == cpu_pkg::OP_HALT) begin
			running = 1'b0;
		end else if (op == cpu_pkg::OP_LPSU) begin
			m_psu[6:0] = m_r0[6:0];
		end else if (op == cpu_pkg::OP_LPSL) begin
			m_psl = m_r0;
		end else if (op == cpu_pkg::OP_SPSU) begin
			m_psu[7] = m_sense; // Sense level seen in bit 7
			m_r0 = m_psu;
			m_psl[7:6] = cc_from(m_psu);
		end else if (op == cpu_pkg::OP_SPSL) begin
			m_r0 = m_psl;
			m_psl[7:6] = cc_from(m_r0);
		end else if (op[7:3] == 5'b00011 || (op[7:3] == 5'b10011 && r != 2'd3)) begin
			taken = op[7] ? (r != m_psl[7:6]) : (r == 2'd3 || r == m_psl[7:6]);
			if (!taken) begin
				pc = pc + (op[2] ? 2 : 1);
			end else if (!op[2]) begin
				b1 = read_bus(pc);
				pc++;
				pc = pc + {{(ADDR_W-7){b1[6]}}, b1[6:0]};
			end else begin
				b1 = read_bus(pc);
				b2 = read_bus(pc + 1'b1);
				pc = ADDR_W'({b1[4:0], b2});
			end
		end else if (!op[4] && op[3:2] == 2'd1 && op[7:5] != 3'd6) begin
			b1 = read_bus(pc);
			pc++;
			exec_alu(op[7:5], r, b1);
		end else if (!op[4] && op[3:2] == 2'd3) begin
			b1 = read_bus(pc);
			b2 = read_bus(pc + 1'b1);
			pc = pc + 2'd2;
			ea = ADDR_W'({b1[4:0], b2}); // Index and indirect bits ignored
			if (op[7:5] == 3'd6) begin
				exp_wr_addr.push_back(ea);
				exp_wr_data.push_back(get_reg(r));
				m_mem[ea] = get_reg(r);
			end else begin
				exec_alu(op[7:5], r, read_bus(ea));
			end
		end
	end
endtask

// File: sim/tb_as2650.sv
`timescale 1ns/1ns
`default_nettype none

module tb_as2650;

	localparam int ADDR_W = 13;
	localparam int BLOCKS = 40;
	localparam logic [ADDR_W-1:0] DATA_BASE = 13'h1000;

	logic              clk = 1'b0;
	logic              reset;
	logic              sense;
	cpu_pkg::data_t    dbus_in;
	cpu_pkg::data_t    dbus_out;
	logic [ADDR_W-1:0] adr;
	logic              opreq;
	logic              rw;
	logic              wrp;
	logic              flag;

	cpu_pkg::data_t    mem [0:8191];
	logic              sense_mark [0:8191]; // Block start addresses
	logic              sense_val [0:8191];
	int                seed = 32'h507f_06e2;
	logic [ADDR_W-1:0] gen_pc;
	int                limit = 0;
	int                cycles = 0;
	int                errors = 0;
	int                n_reads = 0;
	int                n_writes = 0;
	int                n_flags = 0;

	`include "ref_model.svh"

	as2650_core #(.ADDR_W(ADDR_W)) as2650_core_inst (.clk, .reset, .dbus_in, .dbus_out,
		.adr, .opreq, .rw, .wrp, .sense, .flag);

	always #10 clk = ~clk;

	assign dbus_in = (opreq && !rw) ? mem[adr] : 8'h00;

	function automatic int unsigned rnd();
		return $random(seed);
	endfunction

	function automatic logic [ADDR_W-1:0] data_addr();
		return DATA_BASE | ADDR_W'(8'(rnd()));
	endfunction

	task automatic put_byte(input cpu_pkg::data_t v);
		mem[gen_pc] = v;
		gen_pc++;
	endtask

	task automatic put_abs(input logic [ADDR_W-1:0] a);
		put_byte({3'(rnd()), a[12:8]}); // Random index and indirect bits
		put_byte(a[7:0]);
	endtask

	task automatic build_program();
		int                kind;
		int                nfill;
		logic [1:0]        r;
		logic [2:0]        op3;
		logic              is_abs;
		logic              is_false;
		logic [ADDR_W-1:0] target;
		gen_pc = '0;
		for (int blk = 0; blk < BLOCKS; blk++) begin
			sense_mark[gen_pc] = 1'b1;
			sense_val[gen_pc] = 1'(rnd());
			kind = rnd() % 7;
			r = 2'(rnd());
			case (kind)
				0: begin // Bank switch and random mode bits
					put_byte(8'h04);
					put_byte(8'(rnd()));
					put_byte(cpu_pkg::OP_LPSL);
				end
				1: begin
					op3 = 3'(rnd() % 7);
					if (op3 == 3'd6) begin
						op3 = 3'd7;
					end
					put_byte({op3, 3'b001, r});
					put_byte(8'(rnd()));
					put_byte({6'b110011, r}); // Store the result to see it
					put_abs(data_addr());
					if (1'(rnd())) begin
						put_byte(cpu_pkg::OP_SPSL); // Flags of the ALU op
						put_byte(8'hCC);
						put_abs(data_addr());
					end
				end
				2: begin
					put_byte({6'b000011, r});
					put_abs(data_addr());
				end
				3: begin
					is_abs = 1'(rnd());
					is_false = 1'(rnd());
					nfill = 1 + rnd() % 3;
					if (is_false && r == 2'd3) begin
						r = 2'd2;
					end
					target = gen_pc + (is_abs ? 3 : 2) + nfill;
					put_byte({is_false, 4'b0011, is_abs, r});
					if (is_abs) begin
						put_abs(target);
					end else begin
						put_byte(8'(nfill) | (8'(rnd()) & 8'h80));
					end
					repeat (nfill) put_byte(cpu_pkg::OP_NOP); // Fall-through path
				end
				4: begin // Nop lets the new sense level settle
					put_byte(cpu_pkg::OP_NOP);
					put_byte(cpu_pkg::OP_SPSU);
					put_byte(8'hCC);
					put_abs(data_addr());
				end
				5: begin
					put_byte(8'h04);
					put_byte(8'(rnd()));
					put_byte(cpu_pkg::OP_LPSU);
				end
				default: begin
					put_byte({6'b110011, r});
					put_abs(data_addr());
				end
			endcase
		end
		put_byte(cpu_pkg::OP_HALT);
	endtask

	task automatic check_fetch(input logic [ADDR_W-1:0] got);
		logic [ADDR_W-1:0] exp;
		n_reads++;
		if (exp_rd_addr.size() == 0) begin
			errors++;
			$display("Bus read at address %h after the program ended, time %0t", got, $time);
			return;
		end
		exp = exp_rd_addr.pop_front();
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: read address %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_flag(input logic got);
		logic exp;
		if (exp_rd_flag.size() == 0) begin
			return;
		end
		n_flags++;
		exp = exp_rd_flag.pop_front();
		if (got !== exp) begin
			errors++;
			$display("Fail %0t: flag %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_write(input logic [ADDR_W-1:0] a, input cpu_pkg::data_t d);
		logic [ADDR_W-1:0] exp_a;
		cpu_pkg::data_t    exp_d;
		n_writes++;
		if (exp_wr_addr.size() == 0) begin
			errors++;
			$display("Unexpected write of %h to address %h, time %0t", d, a, $time);
			return;
		end
		exp_a = exp_wr_addr.pop_front();
		exp_d = exp_wr_data.pop_front();
		if (a !== exp_a || d !== exp_d) begin
			errors++;
			$display("Fail %0t: write %h to %h, expected %h to %h", $time, d, a, exp_d, exp_a);
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			if (opreq && !rw) begin
				check_flag(flag);
				check_fetch(adr);
				if (sense_mark[adr]) begin
					sense <= sense_val[adr]; // New level for this block
				end
			end else if (opreq && exp_rd_addr.size() == 0) begin
				errors++;
				$display("opreq went high after halt, time %0t", $time);
			end
			if (wrp) begin
				if (!(opreq && rw)) begin
					errors++;
					$display("Write strobe without opreq and rw both high, time %0t", $time);
				end
				check_write(adr, dbus_out);
				mem[adr] <= dbus_out;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles, the DUT never reached halt", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		sense = 1'b0;
		for (int i = 0; i < 8192; i++) begin
			mem[i] = cpu_pkg::data_t'(i ^ (i >> 5));
			sense_mark[i] = 1'b0;
			sense_val[i] = 1'b0;
		end
		build_program();
		run_model();
		limit = gen_pc * 7 + 100;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		while (exp_rd_addr.size() != 0) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk); // Any read here is flagged
		if (exp_wr_addr.size() != 0) begin
			errors++;
			$display("%0d expected stores never reached the bus", exp_wr_addr.size());
		end
		$display("Reads %0d, writes %0d, flag checks %0d, errors %0d",
			n_reads, n_writes, n_flags, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+sim
hw/cpu_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/status_regs.sv
hw/addr_unit.sv
hw/cpu_sequencer.sv
hw/as2650_core.sv
sim/tb_as2650.sv
